//--- verilog/pc_seq_pkg.sv
// --------------------------------------
// Shared constants and types for the PC sequencer
// Referenced by scoped name from each RTL file
// --------------------------------------
`default_nettype none

package pc_seq_pkg;

    // Thread organisation
    // Three or more threads keep a read away from its own pending write
    localparam int thread_count     = 4;
    localparam int thread_width     = 2;
    localparam int pc_width         = 12;
    // Pipeline depth from RAM read to issue
    localparam int stage_count      = 2;
    // Thread t starts at t * stride
    localparam int thread_pc_stride = 256;

    // Start-address sweep covers one round plus the pipeline fill
    localparam int sweep_cycles      = thread_count + stage_count;
    localparam int sweep_count_width = $clog2(sweep_cycles + 1);

    typedef logic [thread_width-1:0]      thread_t;
    typedef logic [pc_width-1:0]          pc_t;
    typedef logic [sweep_count_width-1:0] sweep_count_t;

    // --------------------------------------
    // Pipeline control word, 15 bits
    typedef struct packed {
        logic io_ready;
        logic cancel;
        logic jump;
        pc_t  jump_destination;
    } ctrl_t;

    // Host redirect request, 14 bits
    typedef struct packed {
        thread_t thread;
        pc_t     target;
    } redirect_t;

    // Issued instruction address, 15 bits
    typedef struct packed {
        logic    valid;
        thread_t thread;
        pc_t     pc;
    } issue_t;

    typedef enum logic {sweep, run} init_state_e;
    typedef enum logic [1:0] {idle, wait_slot, acked} redirect_state_e;

endpackage

`default_nettype wire

//--- verilog/thread_counter.sv
// --------------------------------------
// Round-robin thread number counter
// Loads its start value while rst is high
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module thread_counter (
    input  wire                 clock,
    input  wire                 rst,
    input  wire                 pc_seq_pkg::thread_t start,
    output pc_seq_pkg::thread_t thread
);

    // Last thread number before the wrap
    localparam pc_seq_pkg::thread_t last_thread =
        pc_seq_pkg::thread_t'(pc_seq_pkg::thread_count - 1);

    always_ff @(posedge clock) begin
        if (rst) begin
            thread <= start;
        end else if (thread == last_thread) begin
            thread <= '0;
        end else begin
            thread <= thread + 1'b1;
        end
    end

    // Counter must stay inside the thread range
    thread_in_range_a: assert property (
        @(posedge clock) disable iff (rst)
        int'(thread) < pc_seq_pkg::thread_count
    ) else $error("thread counter left the thread range");

endmodule

`default_nettype wire

//--- verilog/pc_ram.sv
// --------------------------------------
// Simple dual-port RAM, one write port, registered read
// Read during write to the same address returns the old word
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pc_ram #(
    parameter int word_width = pc_seq_pkg::pc_width,
    parameter int depth      = pc_seq_pkg::thread_count
) (
    input  wire                       clock,
    input  wire                       write_enable,
    input  wire  pc_seq_pkg::thread_t write_addr,
    input  wire  [word_width-1:0]     write_data,
    input  wire  pc_seq_pkg::thread_t read_addr,
    output logic [word_width-1:0]     read_data
);

    // One word per thread
    logic [word_width-1:0] mem [depth];

    // --------------------------------------
    // Write port
    always_ff @(posedge clock) begin
        if (write_enable) begin
            mem[write_addr] <= write_data;
        end
    end

    // --------------------------------------
    // Read port, one cycle latency
    always_ff @(posedge clock) begin
        read_data <= mem[read_addr];
    end

    // Addresses above depth would fall outside the array
    write_addr_in_range_a: assert property (
        @(posedge clock) write_enable |-> int'(write_addr) < depth
    ) else $error("RAM write address beyond depth");

endmodule

`default_nettype wire

//--- verilog/pc_controller.sv
// --------------------------------------
// Two-stage PC pipeline with per-thread next and previous values
// Sweeps start addresses after reset, then issues one PC per cycle
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pc_controller (
    input  wire                     clock,
    input  wire                     rst,
    input  wire  pc_seq_pkg::ctrl_t ctrl,
    output pc_seq_pkg::thread_t     read_thread,
    output pc_seq_pkg::issue_t      issue
);

    // Write thread trails the read thread by the pipeline depth
    localparam pc_seq_pkg::thread_t write_start =
        pc_seq_pkg::thread_t'(pc_seq_pkg::thread_count - pc_seq_pkg::stage_count);
    // Thread sitting in stage 1 right after reset
    localparam pc_seq_pkg::thread_t stage1_start =
        pc_seq_pkg::thread_t'(pc_seq_pkg::thread_count - 1);

    pc_seq_pkg::thread_t      write_thread;
    pc_seq_pkg::init_state_e  state;
    pc_seq_pkg::sweep_count_t sweep_count;

    pc_seq_pkg::pc_t   next_pc;
    pc_seq_pkg::pc_t   prev_pc;
    pc_seq_pkg::pc_t   start_pc;
    pc_seq_pkg::pc_t   next_write_data;
    pc_seq_pkg::pc_t   prev_write_data;
    pc_seq_pkg::pc_t   chosen_pc;
    pc_seq_pkg::pc_t   issue_pc;
    pc_seq_pkg::ctrl_t ctrl_s1;
    pc_seq_pkg::thread_t thread_s1;
    pc_seq_pkg::thread_t issue_thread;
    logic              reissue;

    // --------------------------------------
    // Thread numbers
    thread_counter read_counter_i (
        .clock  (clock),
        .rst    (rst),
        .start  (pc_seq_pkg::thread_t'(0)),
        .thread (read_thread)
    );

    thread_counter write_counter_i (
        .clock  (clock),
        .rst    (rst),
        .start  (write_start),
        .thread (write_thread)
    );

    // --------------------------------------
    // Stage 0: read both memories, register the control word
    pc_ram #(
        .word_width (pc_seq_pkg::pc_width),
        .depth      (pc_seq_pkg::thread_count)
    ) next_mem_i (
        .clock        (clock),
        .write_enable (1'b1),
        .write_addr   (write_thread),
        .write_data   (next_write_data),
        .read_addr    (read_thread),
        .read_data    (next_pc)
    );

    pc_ram #(
        .word_width (pc_seq_pkg::pc_width),
        .depth      (pc_seq_pkg::thread_count)
    ) prev_mem_i (
        .clock        (clock),
        .write_enable (1'b1),
        .write_addr   (write_thread),
        .write_data   (prev_write_data),
        .read_addr    (read_thread),
        .read_data    (prev_pc)
    );

    always_ff @(posedge clock) begin
        ctrl_s1 <= ctrl;
    end

    // --------------------------------------
    // Stage 1: pick the new PC
    // Cancel beats the IO stall re-issue
    always_comb begin
        reissue = !ctrl_s1.io_ready && !ctrl_s1.cancel;
        if (reissue) begin
            chosen_pc = prev_pc;
        end else if (ctrl_s1.jump) begin
            chosen_pc = ctrl_s1.jump_destination;
        end else begin
            chosen_pc = next_pc;
        end
    end

    always_ff @(posedge clock) begin
        issue_pc <= chosen_pc;
    end

    // Thread tags start aligned with the write counter
    always_ff @(posedge clock) begin
        if (rst) begin
            thread_s1    <= stage1_start;
            issue_thread <= write_start;
        end else begin
            thread_s1    <= read_thread;
            issue_thread <= thread_s1;
        end
    end

    // --------------------------------------
    // Write-back, start address while sweeping
    assign start_pc = pc_seq_pkg::pc_t'(write_thread) *
                      pc_seq_pkg::pc_t'(pc_seq_pkg::thread_pc_stride);

    // Increment wraps at the counter width
    assign next_write_data = (state == pc_seq_pkg::sweep) ? start_pc : issue_pc + 1'b1;
    assign prev_write_data = (state == pc_seq_pkg::sweep) ? start_pc : issue_pc;

    // --------------------------------------
    // Init FSM
    // Sweep also spans the pipeline fill so no stale PC gets written back
    always_ff @(posedge clock) begin
        if (rst) begin
            state       <= pc_seq_pkg::sweep;
            sweep_count <= '0;
        end else if (state == pc_seq_pkg::sweep) begin
            if (sweep_count == pc_seq_pkg::sweep_count_t'(pc_seq_pkg::sweep_cycles - 1)) begin
                state <= pc_seq_pkg::run;
            end
            sweep_count <= sweep_count + 1'b1;
        end
    end

    assign issue = '{
        valid:  (state == pc_seq_pkg::run),
        thread: issue_thread,
        pc:     issue_pc
    };

    // Issued PC is written back to its own thread
    issue_matches_write_a: assert property (
        @(posedge clock) disable iff (rst)
        issue.thread == write_thread
    ) else $error("issued thread differs from write thread");

    // Once up, valid holds until the next reset
    valid_sticky_a: assert property (
        @(posedge clock) $fell(issue.valid) |-> $past(rst)
    ) else $error("issue valid dropped without reset");

endmodule

`default_nettype wire

//--- verilog/host_redirect.sv
// --------------------------------------
// Four-phase host port forcing a thread to a new PC
// Injects the redirect in the target thread's read slot
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module host_redirect (
    input  wire                         clock,
    input  wire                         rst,
    input  wire                         req,
    input  wire  pc_seq_pkg::redirect_t redirect,
    output logic                        ack,
    input  wire  pc_seq_pkg::thread_t   read_thread,
    input  wire  pc_seq_pkg::ctrl_t     pipe_ctrl,
    output pc_seq_pkg::ctrl_t           ctrl
);

    pc_seq_pkg::redirect_state_e state;
    pc_seq_pkg::redirect_t       captured;
    logic                        slot_hit;

    // Target thread is being read this cycle
    assign slot_hit = (state == pc_seq_pkg::wait_slot) &&
                      (read_thread == captured.thread);

    // Ack rises with the override and holds until req drops
    assign ack = slot_hit || (state == pc_seq_pkg::acked);

    // --------------------------------------
    // Control word override
    // cancel suppresses any re-issue, jump carries the target
    always_comb begin
        ctrl = pipe_ctrl;
        if (slot_hit) begin
            ctrl.io_ready         = 1'b1;
            ctrl.cancel           = 1'b1;
            ctrl.jump             = 1'b1;
            ctrl.jump_destination = captured.target;
        end
    end

    // --------------------------------------
    // Handshake FSM
    always_ff @(posedge clock) begin
        if (rst) begin
            state <= pc_seq_pkg::idle;
        end else begin
            case (state)
                pc_seq_pkg::idle: begin
                    if (req) begin
                        state <= pc_seq_pkg::wait_slot;
                    end
                end
                pc_seq_pkg::wait_slot: begin
                    if (slot_hit) begin
                        state <= pc_seq_pkg::acked;
                    end
                end
                pc_seq_pkg::acked: begin
                    // Ack falls the cycle after req is seen low
                    if (!req) begin
                        state <= pc_seq_pkg::idle;
                    end
                end
                default: state <= pc_seq_pkg::idle;
            endcase
        end
    end

    // Request data is stable while req is high
    always_ff @(posedge clock) begin
        if (state == pc_seq_pkg::idle && req) begin
            captured <= redirect;
        end
    end

    ack_needs_req_a: assert property (
        @(posedge clock) disable iff (rst)
        $rose(ack) |-> req
    ) else $error("host ack raised without req");

    // Exactly one forced control word per request
    override_one_cycle_a: assert property (
        @(posedge clock) disable iff (rst)
        slot_hit |=> !slot_hit
    ) else $error("redirect override held for more than one cycle");

endmodule

`default_nettype wire

//--- verilog/pc_sequencer_top.sv
// --------------------------------------
// PC sequencer top, host port ahead of the controller
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pc_sequencer_top (
    input  wire                         clock,
    input  wire                         rst,
    input  wire  pc_seq_pkg::ctrl_t     pipe_ctrl,
    input  wire                         host_req,
    input  wire  pc_seq_pkg::redirect_t host_redirect_data,
    output logic                        host_ack,
    output pc_seq_pkg::issue_t          issue
);

    // Control word after the host override
    pc_seq_pkg::ctrl_t   ctrl;
    // Thread whose memories are read this cycle
    pc_seq_pkg::thread_t read_thread;

    // --------------------------------------
    // Host port
    host_redirect host_redirect_i (
        .clock       (clock),
        .rst         (rst),
        .req         (host_req),
        .redirect    (host_redirect_data),
        .ack         (host_ack),
        .read_thread (read_thread),
        .pipe_ctrl   (pipe_ctrl),
        .ctrl        (ctrl)
    );

    // --------------------------------------
    // PC pipeline
    pc_controller pc_controller_i (
        .clock       (clock),
        .rst         (rst),
        .ctrl        (ctrl),
        .read_thread (read_thread),
        .issue       (issue)
    );

endmodule

`default_nettype wire

//--- dv/tb_pc_sequencer.sv
// --------------------------------------
// Testbench for the PC sequencer top, LCG control words
// Host redirects checked against a per-thread reference model
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_pc_sequencer;

    // First cycle after reset with valid high, and the host ack limit
    localparam int first_valid = pc_seq_pkg::thread_count + 2;
    localparam int ack_timeout = pc_seq_pkg::thread_count + 2;
    localparam pc_seq_pkg::ctrl_t safe_ctrl =
        '{io_ready: 1'b1, cancel: 1'b0, jump: 1'b0, jump_destination: '0};
    localparam pc_seq_pkg::ctrl_t stall_ctrl =
        '{io_ready: 1'b0, cancel: 1'b0, jump: 1'b0, jump_destination: '0};
    localparam pc_seq_pkg::ctrl_t top_jump =
        '{io_ready: 1'b1, cancel: 1'b0, jump: 1'b1, jump_destination: '1};
    localparam pc_seq_pkg::ctrl_t other_jump =
        '{io_ready: 1'b1, cancel: 1'b0, jump: 1'b1, jump_destination: 12'h555};

    logic                  clock;
    logic                  rst;
    pc_seq_pkg::ctrl_t     pipe_ctrl;
    logic                  host_req;
    pc_seq_pkg::redirect_t host_redirect_data;
    logic                  host_ack;
    pc_seq_pkg::issue_t    issue;

    // Reference model, last issued PC and applied control word per thread
    pc_seq_pkg::pc_t       last_pc [pc_seq_pkg::thread_count];
    pc_seq_pkg::ctrl_t     applied_ctrl [pc_seq_pkg::thread_count];
    pc_seq_pkg::redirect_t pending;
    // Expected handshake phase of the host port
    pc_seq_pkg::redirect_state_e host_phase;
    int                    cycle_index;
    logic [31:0]           lcg_state;
    int                    value_errors;
    int                    other_errors;
    int                    reissue_count;
    int                    cancel_count;
    int                    wrap_count;
    logic                  valid_seen;

    pc_sequencer_top dut_i (
        .clock              (clock),
        .rst                (rst),
        .pipe_ctrl          (pipe_ctrl),
        .host_req           (host_req),
        .host_redirect_data (host_redirect_data),
        .host_ack           (host_ack),
        .issue              (issue)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // --------------------------------------
    // Helpers
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Issue rule: stall re-issue first, then jump, else increment
    function automatic pc_seq_pkg::pc_t predict_pc(pc_seq_pkg::ctrl_t c, pc_seq_pkg::pc_t last);
        if (!c.io_ready && !c.cancel) begin
            return last;
        end else if (c.jump) begin
            return c.jump_destination;
        end
        return last + 12'd1;
    endfunction

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
        value_errors++;
    endtask

    task automatic report_failure(input string reason);
        $display("%s", reason);
        other_errors++;
    endtask

    task automatic abort_run(input string reason);
        report_failure(reason);
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic hold_ctrl(input pc_seq_pkg::ctrl_t c, input int cycles);
        repeat (cycles) begin
            pipe_ctrl = c;
            @(posedge clock);
            #1;
        end
    endtask

    // Roughly a quarter stalls, half of those cancelled, a quarter jumps
    task automatic drive_random(input int cycles);
        logic [31:0] r;
        logic [31:0] d;
        repeat (cycles) begin
            r = next_random();
            d = next_random();
            pipe_ctrl = '{io_ready: r[16] | r[17], cancel: r[20], jump: r[24] & r[25],
                          jump_destination: d[27:16]};
            @(posedge clock);
            #1;
        end
    endtask

    // --------------------------------------
    // Host four-phase handshake, req held hold cycles past ack
    task automatic redirect_thread(input pc_seq_pkg::thread_t t, input pc_seq_pkg::pc_t target,
                                   input int hold);
        int waited;
        pending = '{thread: t, target: target};
        host_redirect_data = pending;
        host_req = 1'b1;
        waited = 0;
        while (!host_ack && waited < ack_timeout) begin
            @(posedge clock);
            #1;
            waited++;
        end
        if (!host_ack) begin
            abort_run("host ack did not rise within the slot wait limit");
        end else begin
            repeat (hold) begin
                @(posedge clock);
                #1;
            end
            host_req = 1'b0;
            waited = 0;
            while (host_ack && waited < ack_timeout) begin
                @(posedge clock);
                #1;
                waited++;
            end
            if (host_ack) begin
                abort_run("host ack stayed high after req was dropped");
            end
        end
    endtask

    task automatic redirect_all(input pc_seq_pkg::pc_t base);
        for (int t = 0; t < pc_seq_pkg::thread_count; t++) begin
            redirect_thread(pc_seq_pkg::thread_t'(t), base + pc_seq_pkg::pc_t'(64 * t + 5),
                            t % 2 + 1);
            repeat (2) @(posedge clock);
            #1;
        end
    endtask

    // --------------------------------------
    // Per-cycle model check, sampled mid-cycle
    task automatic check_cycle();
        pc_seq_pkg::ctrl_t   applied;
        pc_seq_pkg::thread_t t;
        pc_seq_pkg::pc_t     expected_pc;
        logic                slot_hit;
        logic                ack_expected;
        if (rst) begin
            issue_low_in_reset: assert (!issue.valid) else report_failure("valid high in reset");
            cycle_index = 0;
            host_phase = pc_seq_pkg::idle;
        end else begin
            applied = pipe_ctrl;
            // Override lands in the first read slot of the captured thread
            slot_hit = (host_phase == pc_seq_pkg::wait_slot) &&
                       (int'(pending.thread) == cycle_index % pc_seq_pkg::thread_count);
            ack_expected = slot_hit || (host_phase == pc_seq_pkg::acked);
            host_ack_model: assert (host_ack == ack_expected)
                else report_mismatch("host_ack", int'(ack_expected), int'(host_ack));
            if (slot_hit) begin
                applied.cancel           = 1'b1;
                applied.jump             = 1'b1;
                applied.jump_destination = pending.target;
            end
            // Handshake phase for the next cycle
            case (host_phase)
                pc_seq_pkg::idle: begin
                    if (host_req) begin
                        host_phase = pc_seq_pkg::wait_slot;
                    end
                end
                pc_seq_pkg::wait_slot: begin
                    if (slot_hit) begin
                        host_phase = pc_seq_pkg::acked;
                    end
                end
                default: begin
                    if (!host_req) begin
                        host_phase = pc_seq_pkg::idle;
                    end
                end
            endcase
            if (cycle_index < first_valid) begin
                sweep_valid_low: assert (!issue.valid)
                    else report_failure("issue valid rose before the start-address sweep ended");
            end else begin
                t = pc_seq_pkg::thread_t'((cycle_index - 2) % pc_seq_pkg::thread_count);
                if (cycle_index < first_valid + pc_seq_pkg::thread_count) begin
                    // First round issues the start address
                    expected_pc = pc_seq_pkg::pc_t'(int'(t) * pc_seq_pkg::thread_pc_stride);
                end else begin
                    expected_pc = predict_pc(applied_ctrl[t], last_pc[t]);
                    if (!applied_ctrl[t].io_ready && !applied_ctrl[t].cancel) begin
                        reissue_count++;
                    end else if (!applied_ctrl[t].io_ready) begin
                        cancel_count++;
                    end
                    if (expected_pc == '0 && last_pc[t] == '1) begin
                        wrap_count++;
                    end
                end
                issue_valid_high: assert (issue.valid)
                    else report_mismatch("issue_valid", 1, int'(issue.valid));
                issue_thread_order: assert (issue.thread == t)
                    else report_mismatch("issue_thread", int'(t), int'(issue.thread));
                issue_pc_model: assert (issue.pc == expected_pc)
                    else report_mismatch("issue_pc", int'(expected_pc), int'(issue.pc));
                last_pc[t] = expected_pc;
            end
            applied_ctrl[pc_seq_pkg::thread_t'(cycle_index % pc_seq_pkg::thread_count)] = applied;
            cycle_index++;
        end
    endtask

    initial begin
        @(posedge clock);
        forever begin
            @(negedge clock);
            check_cycle();
        end
    end

    // --------------------------------------
    // Handshake rules
    ack_rise_with_req: assert property (@(posedge clock) disable iff (rst)
        $rose(host_ack) |-> host_req)
        else report_failure("host ack rose while req was low");
    ack_held_with_req: assert property (@(posedge clock) disable iff (rst)
        host_ack && host_req |=> host_ack)
        else report_failure("host ack fell while req was still high");
    ack_falls_after_req: assert property (@(posedge clock) disable iff (rst)
        $fell(host_req) |=> !host_ack)
        else report_failure("host ack did not fall after req fell");
    ack_low_after_reset: assert property (@(posedge clock) rst |=> !host_ack)
        else report_failure("host ack high right after reset");

    // --------------------------------------
    // Stimulus
    initial begin
        lcg_state = 32'd20236;
        value_errors = 0;
        other_errors = 0;
        reissue_count = 0;
        cancel_count = 0;
        wrap_count = 0;
        cycle_index = 0;
        host_phase = pc_seq_pkg::idle;
        rst = 1'b1;
        pipe_ctrl = safe_ctrl;
        host_req = 1'b0;
        host_redirect_data = '0;
        pending = '0;
        repeat (2) @(posedge clock);
        #1;
        rst = 1'b0;
        valid_seen = 1'b0;
        for (int waited = 0; waited <= first_valid + 2 && !valid_seen; waited++) begin
            valid_seen = issue.valid;
            if (!valid_seen) begin
                @(posedge clock);
                #1;
            end
        end
        if (!valid_seen) begin
            abort_run("issue valid never rose after reset");
        end else begin
            // Rest of the first round keeps the start addresses
            hold_ctrl(safe_ctrl, pc_seq_pkg::thread_count);
            drive_random(48);
            // All threads jump to the top address, then wrap to zero
            hold_ctrl(top_jump, pc_seq_pkg::thread_count);
            hold_ctrl(safe_ctrl, 2 * pc_seq_pkg::thread_count);
            // Redirects against a stall, a competing jump and random words
            fork
                hold_ctrl(stall_ctrl, 44);
                redirect_all(12'h100);
            join
            fork
                hold_ctrl(other_jump, 44);
                redirect_all(12'h300);
            join
            fork
                drive_random(44);
                redirect_all(12'h700);
            join
            hold_ctrl(safe_ctrl, 4);
            if (reissue_count == 0) report_failure("no IO stall re-issue was exercised");
            if (cancel_count == 0) report_failure("no cancelled stall was exercised");
            if (wrap_count < pc_seq_pkg::thread_count) report_failure("counter wrap not reached");
            $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
            if (value_errors == 0 && other_errors == 0) begin
                $display("TEST OK");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- filelist.f
verilog/pc_seq_pkg.sv
verilog/thread_counter.sv
verilog/pc_ram.sv
verilog/pc_controller.sv
verilog/host_redirect.sv
verilog/pc_sequencer_top.sv
dv/tb_pc_sequencer.sv

//--- run.sh
#!/bin/sh
# Builds the PC sequencer testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_pc_sequencer \
    -f filelist.f \
    -o sim_pc_sequencer

output=$(./obj_dir/sim_pc_sequencer)
echo "$output"

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
else
    exit 1
fi
